/* bench/i3c_wrapper_tb.sv */
// I3C wrapper testbench: register access, bus frame decoding and access rule checks
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

module i3c_wrapper_tb;

  localparam int n_xfers    = 5;
  localparam int max_cycles = n_xfers * (22 * 2 * `I3C_SCL_HALF + 20) + 500;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   reg_we_i;
  logic                   reg_re_i;
  logic [`I3C_REG_AW-1:0] reg_addr_i;
  logic [31:0]            reg_wdata_i;
  logic [31:0]            reg_rdata_o;
  logic                   sda_i;
  logic                   scl_o;
  logic                   sda_o;
  logic                   sel_od_pp_o;

  // Bus decoder state
  logic        scl_prev = 1'b1;
  logic        sda_prev = 1'b1;
  logic        bit_q[$];
  logic        sel_q[$];
  int          start_cnt = 0;
  int          stop_cnt = 0;
  int          scl_low_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] dat_model [`I3C_DAT_DEPTH];

  i3c_wrapper i3c_wrapper_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .sda_i       (sda_i),
    .scl_o       (scl_o),
    .sda_o       (sda_o),
    .sel_od_pp_o (sel_od_pp_o)
  );

  always #4 clk_i = ~clk_i;

  // Outputs change on the rising edge, so the decoder looks at the falling one
  always @(negedge clk_i) begin
    if (scl_prev && scl_o && sda_prev && !sda_o) begin
      start_cnt++;
      bit_q.delete();
      sel_q.delete();
    end else if (scl_prev && scl_o && !sda_prev && sda_o) begin
      // STOP raises SCL once before SDA, that rise is no data bit
      stop_cnt++;
      void'(bit_q.pop_back());
      void'(sel_q.pop_back());
    end else if (!scl_prev && scl_o) begin
      bit_q.push_back(sda_o);
      sel_q.push_back(sel_od_pp_o);
    end
    if (!scl_o) scl_low_cnt++;
    scl_prev = scl_o;
    sda_prev = sda_o;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run went past %0d clock cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    $display("Test failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_status(input i3c_pkg::status_t got, input i3c_pkg::status_t exp,
                              input string what);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic check_entry(input i3c_pkg::dat_entry_t got, input i3c_pkg::dat_entry_t exp,
                             input string what);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic reg_write(input logic [`I3C_REG_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
  endtask

  // Read data is valid one cycle after the strobe
  task automatic reg_read(input logic [`I3C_REG_AW-1:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i = 1'b0;
    data     = reg_rdata_o;
  endtask

  task automatic write_entry(input logic [`I3C_DAT_AW-1:0] idx, input logic [31:0] word);
    reg_write(`I3C_REG_DAT_ADDR, 32'(idx));
    reg_write(`I3C_REG_DAT_DATA, word);
    dat_model[idx] = word;
  endtask

  task automatic read_entry(input logic [`I3C_DAT_AW-1:0] idx, output logic [31:0] word);
    reg_write(`I3C_REG_DAT_ADDR, 32'(idx));
    reg_read(`I3C_REG_DAT_DATA, word);
  endtask

  task automatic read_status(output i3c_pkg::status_t st);
    logic [31:0] word;
    reg_read(`I3C_REG_STATUS, word);
    st = word;
  endtask

  task automatic start_cmd(input logic [`I3C_DAT_AW-1:0] idx, input logic [7:0] data);
    i3c_pkg::cmd_t cmd;
    cmd         = '0;
    cmd.dat_idx = idx;
    cmd.data    = data;
    reg_write(`I3C_REG_CMD, cmd);
  endtask

  task automatic wait_idle();
    i3c_pkg::status_t st;
    do begin
      read_status(st);
    end while (st.busy);
  endtask

  // Address, RnW and ACK always, data and T-bit only when acknowledged
  task automatic check_frame(input logic [6:0] addr, input logic [7:0] data, input logic acked);
    i3c_pkg::dat_entry_t got;
    i3c_pkg::dat_entry_t exp;
    logic [7:0]          sh;
    logic                t_bit;
    check_word(32'(bit_q.size()), acked ? 32'd18 : 32'd9, "Decoded frame bit count");
    got       = '0;
    exp       = '0;
    got.valid = 1'b1;
    exp.valid = 1'b1;
    exp.dyn_addr = addr;
    for (int i = 0; i < 7; i++) got.dyn_addr = {got.dyn_addr[5:0], bit_q[i]};
    check_entry(got, exp, "Decoded frame address");
    check_bit(bit_q[7], 1'b0, "RnW bit");
    check_bit(bit_q[8], 1'b1, "SDA released at ACK");
    for (int i = 0; i < 9; i++) check_bit(sel_q[i], 1'b0, "Open-drain select on address/ACK");
    if (acked) begin
      sh    = data;
      t_bit = 1'b1;
      for (int i = 0; i < 8; i++) begin
        check_bit(bit_q[9 + i], sh[7], "Data bit");
        check_bit(sel_q[9 + i], 1'b1, "Push-pull select on data bit");
        if (sh[7]) t_bit = ~t_bit;
        sh = {sh[6:0], 1'b0};
      end
      check_bit(bit_q[17], t_bit, "T-bit odd parity");
      check_bit(sel_q[17], 1'b1, "Push-pull select on T-bit");
    end
  endtask

  task automatic run_private_write(input logic acked);
    logic [31:0]      r;
    logic [6:0]       addr;
    logic [7:0]       data;
    int               starts;
    int               stops;
    i3c_pkg::status_t st;
    i3c_pkg::status_t st_exp;
    r    = $urandom;
    addr = r[14:8];
    data = r[23:16];
    write_entry(r[3:0], {1'b1, 24'h0, addr});
    sda_i  = ~acked;
    starts = start_cnt;
    stops  = stop_cnt;
    start_cmd(r[3:0], data);
    wait_idle();
    check_word(32'(start_cnt - starts), 32'd1, "START count");
    check_word(32'(stop_cnt - stops), 32'd1, "STOP count");
    check_frame(addr, data, acked);
    read_status(st);
    st_exp      = '0;
    st_exp.done = acked;
    st_exp.nack = ~acked;
    check_status(st, st_exp, "Status after private write");
    sda_i = 1'b0;
  endtask

  task automatic test_dat_readback();
    logic [31:0]            r;
    logic [31:0]            word;
    logic [`I3C_DAT_AW-1:0] idx_list [10];
    for (int i = 0; i < 10; i++) begin
      r           = $urandom;
      idx_list[i] = r[`I3C_DAT_AW-1:0];
      write_entry(idx_list[i], $urandom);
    end
    for (int i = 0; i < 10; i++) begin
      read_entry(idx_list[i], word);
      check_word(word, dat_model[idx_list[i]], $sformatf("DAT entry %0d", idx_list[i]));
    end
  endtask

  task automatic test_ack();
    run_private_write(1'b1);
  endtask

  task automatic test_nack();
    run_private_write(1'b0);
  endtask

  task automatic test_invalid();
    logic [31:0]      r;
    int               starts;
    int               lows;
    i3c_pkg::status_t st;
    i3c_pkg::status_t st_exp;
    r = $urandom;
    write_entry(r[3:0], {1'b0, r[30:0]});
    starts = start_cnt;
    lows   = scl_low_cnt;
    start_cmd(r[3:0], r[11:4]);
    wait_idle();
    read_status(st);
    st_exp         = '0;
    st_exp.invalid = 1'b1;
    check_status(st, st_exp, "Status after invalid entry");
    check_word(32'(start_cnt - starts), 32'd0, "START for invalid entry");
    check_word(32'(scl_low_cnt - lows), 32'd0, "SCL activity for invalid entry");
    check_bit(scl_o, 1'b1, "SCL idle level");
  endtask

  task automatic test_access_rules();
    logic [31:0]      r;
    logic [31:0]      word;
    logic [31:0]      back;
    int               starts;
    int               lows;
    i3c_pkg::status_t st;
    i3c_pkg::status_t st_exp;
    r    = $urandom;
    word = {1'b1, 24'h0, r[14:8]};
    write_entry(r[3:0], word);
    sda_i = 1'b0;
    start_cmd(r[3:0], r[23:16]);
    // DAT_ADDR still points at the entry in use
    reg_write(`I3C_REG_DAT_DATA, ~word);
    wait_idle();
    read_status(st);
    st_exp          = '0;
    st_exp.done     = 1'b1;
    st_exp.rejected = 1'b1;
    check_status(st, st_exp, "Status after DAT write during transfer");
    read_entry(r[3:0], back);
    check_word(back, word, "Entry after rejected write");
    // Controller disabled
    reg_write(`I3C_REG_CTRL, 32'd0);
    starts = start_cnt;
    lows   = scl_low_cnt;
    start_cmd(r[3:0], r[23:16]);
    repeat (40) @(negedge clk_i);
    read_status(st);
    check_bit(st.busy, 1'b0, "Busy after command while disabled");
    check_word(32'(start_cnt - starts), 32'd0, "START while disabled");
    check_word(32'(scl_low_cnt - lows), 32'd0, "SCL activity while disabled");
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    sda_i       = 1'b0;
    void'($urandom(32'h2066));
    for (int i = 0; i < `I3C_DAT_DEPTH; i++) dat_model[i] = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_dat_readback();
    reg_write(`I3C_REG_CTRL, 32'd1);
    test_ack();
    test_nack();
    test_invalid();
    test_access_rules();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/i3c_pkg.sv
hw/i3c_if.sv
hw/i3c_csr.sv
hw/i3c_dat_mem.sv
hw/i3c_ctrl.sv
hw/i3c_bit_engine.sv
hw/i3c_wrapper.sv
bench/i3c_wrapper_tb.sv

/* hw/i3c_bit_engine.sv */
// I3C bit engine: SCL and SDA shaping for START, data bits, ACK sampling and STOP
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

module i3c_bit_engine (
  input  logic        clk_i,
  input  logic        rst_n_i,
  i3c_bit_if.engine   bus,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        sel_od_pp_o
);

  localparam int cnt_w = $clog2(`I3C_SCL_HALF + 1);

  i3c_pkg::bit_op_e op_q;
  logic             active_q;
  logic             tx_q;
  logic [1:0]       ph_q;
  logic [cnt_w-1:0] cnt_q;
  logic             scl_q;
  logic             sda_q;
  logic             rx_q;
  logic             done_q;
  logic             ph_end;
  logic             last_ph;

  // Line levels {scl, sda} held during a given phase of an operation
  function automatic logic [1:0] levels(input i3c_pkg::bit_op_e op, input logic [1:0] ph,
                                        input logic tx);
    logic [1:0] lv;
    case (op)
      i3c_pkg::OP_START: lv = {ph == 2'd0, 1'b0};
      i3c_pkg::OP_ACK:   lv = {ph == 2'd1, 1'b1};
      i3c_pkg::OP_STOP:  lv = {ph != 2'd0, ph == 2'd2};
      default:           lv = {ph == 2'd1, tx};
    endcase
    return lv;
  endfunction

  assign ph_end  = cnt_q == cnt_w'(`I3C_SCL_HALF - 1);
  // STOP needs an extra phase for SDA to rise with SCL high
  assign last_ph = (op_q == i3c_pkg::OP_STOP) ? (ph_q == 2'd2) : (ph_q == 2'd1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      op_q     <= i3c_pkg::OP_START;
      tx_q     <= 1'b0;
      ph_q     <= '0;
      cnt_q    <= '0;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
      rx_q     <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!active_q) begin
        if (bus.op_valid) begin
          active_q       <= 1'b1;
          op_q           <= bus.op;
          tx_q           <= bus.tx_bit;
          ph_q           <= 2'd0;
          cnt_q          <= '0;
          {scl_q, sda_q} <= levels(bus.op, 2'd0, bus.tx_bit);
        end
      end else if (!ph_end) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!last_ph) begin
        cnt_q          <= '0;
        ph_q           <= ph_q + 2'd1;
        {scl_q, sda_q} <= levels(op_q, ph_q + 2'd1, tx_q);
      end else begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
        // Park SCL low between ops, bus idle after STOP
        if (op_q != i3c_pkg::OP_STOP) scl_q <= 1'b0;
        // Target drives ACK by end of the high phase
        if (op_q == i3c_pkg::OP_ACK) rx_q <= sda_i;
      end
    end
  end

  assign bus.op_done = done_q;
  assign bus.rx_bit  = rx_q;

  assign scl_o       = scl_q;
  assign sda_o       = sda_q;
  assign sel_od_pp_o = active_q && (op_q == i3c_pkg::OP_BIT_PP);

endmodule

`default_nettype wire

/* hw/i3c_csr.sv */
// I3C register block: host strobe decode, DAT access, command launch and sticky status
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

module i3c_csr (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_we_i,
  input  logic                   reg_re_i,
  input  logic [`I3C_REG_AW-1:0] reg_addr_i,
  input  logic [31:0]            reg_wdata_i,
  output logic [31:0]            reg_rdata_o,
  i3c_mem_if.requester           mem,
  output logic                   cmd_go_o,
  output i3c_pkg::cmd_t          cmd_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  input  logic                   nack_i,
  input  logic                   invalid_i
);

  logic                   wr_dat;
  logic                   rd_dat;
  logic                   ctrl_en_q;
  logic [`I3C_DAT_AW-1:0] dat_addr_q;
  logic                   done_q;
  logic                   nack_q;
  logic                   invalid_q;
  logic                   rejected_q;
  logic                   dat_rd_q;
  logic [31:0]            rdata_q;
  i3c_pkg::cmd_t          cmd_q;
  i3c_pkg::status_t       status;

  assign wr_dat = reg_we_i && (reg_addr_i == `I3C_REG_DAT_DATA);
  assign rd_dat = reg_re_i && (reg_addr_i == `I3C_REG_DAT_DATA);

  // Host reaches the DAT only between transfers
  assign mem.req   = (wr_dat | rd_dat) & ~busy_i;
  assign mem.we    = wr_dat;
  assign mem.addr  = dat_addr_q;
  assign mem.wdata = reg_wdata_i;

  assign cmd_go_o = reg_we_i && (reg_addr_i == `I3C_REG_CMD) && ctrl_en_q && !busy_i;
  assign cmd_o    = reg_wdata_i;

  always_comb begin
    status          = '0;
    status.busy     = busy_i;
    status.done     = done_q;
    status.nack     = nack_q;
    status.invalid  = invalid_q;
    status.rejected = rejected_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_en_q  <= 1'b0;
      dat_addr_q <= '0;
      done_q     <= 1'b0;
      nack_q     <= 1'b0;
      invalid_q  <= 1'b0;
      rejected_q <= 1'b0;
      dat_rd_q   <= 1'b0;
    end else begin
      if (reg_we_i && (reg_addr_i == `I3C_REG_CTRL)) begin
        ctrl_en_q <= reg_wdata_i[0];
      end
      if (reg_we_i && (reg_addr_i == `I3C_REG_DAT_ADDR)) begin
        dat_addr_q <= reg_wdata_i[`I3C_DAT_AW-1:0];
      end
      // New command wipes the previous outcome
      if (cmd_go_o) begin
        done_q     <= 1'b0;
        nack_q     <= 1'b0;
        invalid_q  <= 1'b0;
        rejected_q <= 1'b0;
      end else begin
        if (done_i) done_q <= 1'b1;
        if (nack_i) nack_q <= 1'b1;
        if (invalid_i) invalid_q <= 1'b1;
        if ((wr_dat | rd_dat) & busy_i) rejected_q <= 1'b1;
      end
      dat_rd_q <= rd_dat & ~busy_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_go_o) begin
      cmd_q <= cmd_o;
    end
    if (reg_re_i) begin
      case (reg_addr_i)
        `I3C_REG_CTRL:     rdata_q <= {31'b0, ctrl_en_q};
        `I3C_REG_STATUS:   rdata_q <= status;
        `I3C_REG_CMD:      rdata_q <= cmd_q;
        `I3C_REG_DAT_ADDR: rdata_q <= 32'(dat_addr_q);
        default:           rdata_q <= '0;
      endcase
    end
  end

  // DAT words come straight from the memory, already one cycle late
  assign reg_rdata_o = dat_rd_q ? mem.rdata : rdata_q;

endmodule

`default_nettype wire

/* hw/i3c_ctrl.sv */
// I3C controller FSM: DAT entry fetch and private write sequencing
`timescale 1ns/1ps
`default_nettype none

module i3c_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cmd_go_i,
  input  i3c_pkg::cmd_t        cmd_i,
  i3c_mem_if.requester         mem,
  i3c_bit_if.ctrl              bus,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 nack_o,
  output logic                 invalid_o
);

  i3c_pkg::ctrl_state_e state_q;
  i3c_pkg::cmd_t        cmd_q;
  i3c_pkg::dat_entry_t  entry;
  i3c_pkg::bit_op_e     op_q;
  logic                 req_q;
  logic [8:0]           sh_q;
  logic [3:0]           cnt_q;
  logic                 nack_seen_q;
  logic                 op_valid_q;
  logic                 done_q;
  logic                 nack_q;
  logic                 invalid_q;

  assign entry = mem.rdata;

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = cmd_q.dat_idx;
  assign mem.wdata = '0;

  // Next bit to send is always the top of the shifter
  assign bus.op_valid = op_valid_q;
  assign bus.op       = op_q;
  assign bus.tx_bit   = sh_q[8];

  assign busy_o    = state_q != i3c_pkg::IDLE;
  assign done_o    = done_q;
  assign nack_o    = nack_q;
  assign invalid_o = invalid_q;

  always_ff @(posedge clk_i) begin
    if ((state_q == i3c_pkg::IDLE) && cmd_go_i) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= i3c_pkg::IDLE;
      op_q        <= i3c_pkg::OP_START;
      req_q       <= 1'b0;
      sh_q        <= '0;
      cnt_q       <= '0;
      nack_seen_q <= 1'b0;
      op_valid_q  <= 1'b0;
      done_q      <= 1'b0;
      nack_q      <= 1'b0;
      invalid_q   <= 1'b0;
    end else begin
      op_valid_q <= 1'b0;
      done_q     <= 1'b0;
      nack_q     <= 1'b0;
      invalid_q  <= 1'b0;
      case (state_q)
        i3c_pkg::IDLE: begin
          if (cmd_go_i) begin
            req_q       <= 1'b1;
            nack_seen_q <= 1'b0;
            state_q     <= i3c_pkg::FETCH;
          end
        end
        i3c_pkg::FETCH: begin
          // First cycle issues the read, second one sees the entry
          if (req_q) begin
            req_q <= 1'b0;
          end else if (!entry.valid) begin
            invalid_q <= 1'b1;
            state_q   <= i3c_pkg::IDLE;
          end else begin
            sh_q       <= {entry.dyn_addr, 2'b00};
            op_valid_q <= 1'b1;
            op_q       <= i3c_pkg::OP_START;
            state_q    <= i3c_pkg::START;
          end
        end
        i3c_pkg::START: begin
          if (bus.op_done) begin
            op_valid_q <= 1'b1;
            op_q       <= i3c_pkg::OP_BIT_OD;
            cnt_q      <= 4'd7;
            state_q    <= i3c_pkg::ADDR;
          end
        end
        i3c_pkg::ADDR: begin
          if (bus.op_done) begin
            op_valid_q <= 1'b1;
            if (cnt_q != 0) begin
              sh_q  <= {sh_q[7:0], 1'b0};
              cnt_q <= cnt_q - 4'd1;
              op_q  <= i3c_pkg::OP_BIT_OD;
            end else begin
              op_q    <= i3c_pkg::OP_ACK;
              state_q <= i3c_pkg::ACK;
            end
          end
        end
        i3c_pkg::ACK: begin
          if (bus.op_done) begin
            op_valid_q <= 1'b1;
            if (bus.rx_bit) begin
              nack_seen_q <= 1'b1;
              op_q        <= i3c_pkg::OP_STOP;
              state_q     <= i3c_pkg::STOP;
            end else begin
              // Data byte then T-bit with odd parity
              sh_q    <= {cmd_q.data, ~^cmd_q.data};
              cnt_q   <= 4'd8;
              op_q    <= i3c_pkg::OP_BIT_PP;
              state_q <= i3c_pkg::DATA;
            end
          end
        end
        i3c_pkg::DATA: begin
          if (bus.op_done) begin
            op_valid_q <= 1'b1;
            if (cnt_q != 0) begin
              sh_q  <= {sh_q[7:0], 1'b0};
              cnt_q <= cnt_q - 4'd1;
              op_q  <= i3c_pkg::OP_BIT_PP;
            end else begin
              op_q    <= i3c_pkg::OP_STOP;
              state_q <= i3c_pkg::STOP;
            end
          end
        end
        i3c_pkg::STOP: begin
          if (bus.op_done) begin
            state_q <= i3c_pkg::IDLE;
            if (nack_seen_q) nack_q <= 1'b1;
            else done_q <= 1'b1;
          end
        end
        default: state_q <= i3c_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/i3c_dat_mem.sv */
// I3C Device Address Table: single-port synchronous RAM shared by host and controller
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

module i3c_dat_mem (
  input  logic       clk_i,
  input  logic       rst_n_i,
  i3c_mem_if.memory  host,
  i3c_mem_if.memory  fetch
);

  logic [31:0]            mem_q [`I3C_DAT_DEPTH];
  logic                   port_req;
  logic                   port_we;
  logic [`I3C_DAT_AW-1:0] port_addr;
  logic [31:0]            port_wdata;
  logic [31:0]            rdata_q;
  logic                   host_rsp_q;
  logic                   fetch_rsp_q;

  // Controller fetch takes the port over the host
  assign port_req   = fetch.req | host.req;
  assign port_we    = fetch.req ? fetch.we : host.we;
  assign port_addr  = fetch.req ? fetch.addr : host.addr;
  assign port_wdata = fetch.req ? fetch.wdata : host.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `I3C_DAT_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_q     <= '0;
      host_rsp_q  <= 1'b0;
      fetch_rsp_q <= 1'b0;
    end else begin
      host_rsp_q  <= host.req & ~fetch.req;
      fetch_rsp_q <= fetch.req;
      if (port_req) begin
        if (port_we) mem_q[port_addr] <= port_wdata;
        else rdata_q <= mem_q[port_addr];
      end
    end
  end

  assign host.rdata  = host_rsp_q ? rdata_q : '0;
  assign fetch.rdata = fetch_rsp_q ? rdata_q : '0;

endmodule

`default_nettype wire

/* hw/i3c_if.sv */
// I3C internal links: DAT memory access port and controller to bit engine channel
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

interface i3c_mem_if;
  logic                   req;
  logic                   we;
  logic [`I3C_DAT_AW-1:0] addr;
  logic [31:0]            wdata;
  // Valid the cycle after req
  logic [31:0]            rdata;

  modport requester (output req, output we, output addr, output wdata, input rdata);
  modport memory (input req, input we, input addr, input wdata, output rdata);
endinterface

interface i3c_bit_if;
  logic              op_valid;
  i3c_pkg::bit_op_e  op;
  logic              tx_bit;
  logic              op_done;
  logic              rx_bit;

  modport ctrl (output op_valid, output op, output tx_bit, input op_done, input rx_bit);
  modport engine (input op_valid, input op, input tx_bit, output op_done, output rx_bit);
endinterface

`default_nettype wire

/* hw/i3c_macros.svh */
// I3C controller configuration: DAT size, register map and SCL timing
`ifndef I3C_MACROS_SVH
`define I3C_MACROS_SVH

// Device Address Table
`define I3C_DAT_DEPTH 16
`define I3C_DAT_AW 4

// Register word addresses
`define I3C_REG_AW 3
`define I3C_REG_CTRL 0
`define I3C_REG_STATUS 1
`define I3C_REG_CMD 2
`define I3C_REG_DAT_ADDR 3
`define I3C_REG_DAT_DATA 4

// clk_i cycles per SCL half period, 1 or more
`define I3C_SCL_HALF 2

`endif

/* hw/i3c_pkg.sv */
// I3C controller types: FSM states, bit opcodes and register word layouts
`default_nettype none

`include "i3c_macros.svh"

package i3c_pkg;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    START,
    ADDR,
    ACK,
    DATA,
    STOP
  } ctrl_state_e;

  typedef enum logic [2:0] {
    OP_START,
    OP_BIT_OD,
    OP_BIT_PP,
    OP_ACK,
    OP_STOP
  } bit_op_e;

  typedef struct packed {
    logic        valid;
    logic [23:0] rsvd;
    logic [6:0]  dyn_addr;
  } dat_entry_t;

  typedef struct packed {
    logic [31-8-`I3C_DAT_AW:0] rsvd;
    logic [`I3C_DAT_AW-1:0]    dat_idx;
    logic [7:0]                data;
  } cmd_t;

  typedef struct packed {
    logic [26:0] rsvd;
    logic        rejected;
    logic        invalid;
    logic        nack;
    logic        done;
    logic        busy;
  } status_t;

endpackage

`default_nettype wire

/* hw/i3c_wrapper.sv */
// I3C controller subsystem top: register port, controller core, DAT memory and bus pins
`timescale 1ns/1ps
`default_nettype none

`include "i3c_macros.svh"

module i3c_wrapper (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_we_i,
  input  logic                   reg_re_i,
  input  logic [`I3C_REG_AW-1:0] reg_addr_i,
  input  logic [31:0]            reg_wdata_i,
  output logic [31:0]            reg_rdata_o,
  // Bus pins exposed for Verilator, no IO cell
  input  logic                   sda_i,
  output logic                   scl_o,
  output logic                   sda_o,
  output logic                   sel_od_pp_o
);

  logic          cmd_go;
  i3c_pkg::cmd_t cmd;
  logic          busy;
  logic          done;
  logic          nack;
  logic          invalid;

  // DAT access from host and controller
  i3c_mem_if host_mem ();
  i3c_mem_if fetch_mem ();

  i3c_bit_if bit_bus ();

  i3c_csr i3c_csr_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .mem         (host_mem.requester),
    .cmd_go_o    (cmd_go),
    .cmd_o       (cmd),
    .busy_i      (busy),
    .done_i      (done),
    .nack_i      (nack),
    .invalid_i   (invalid)
  );

  i3c_dat_mem i3c_dat_mem_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .host    (host_mem.memory),
    .fetch   (fetch_mem.memory)
  );

  i3c_ctrl i3c_ctrl_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cmd_go_i  (cmd_go),
    .cmd_i     (cmd),
    .mem       (fetch_mem.requester),
    .bus       (bit_bus.ctrl),
    .busy_o    (busy),
    .done_o    (done),
    .nack_o    (nack),
    .invalid_o (invalid)
  );

  i3c_bit_engine i3c_bit_engine_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus         (bit_bus.engine),
    .sda_i       (sda_i),
    .scl_o       (scl_o),
    .sda_o       (sda_o),
    .sel_od_pp_o (sel_od_pp_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the I3C wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module i3c_wrapper_tb -o i3c_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/i3c_sim 2>&1)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
